/* armCtrlPkg.sv */
`default_nettype none

package armCtrlPkg;

  // ==========================================================
  // Plain vector types
  // ==========================================================
  typedef logic [31:0] instrT;       // Raw instruction word
  typedef logic [3:0]  flagsT;       // {N, Z, C, V}
  typedef logic [3:0]  condT;        // Instr[31:28]
  typedef logic [3:0]  aluCtrlT;     // DP opcode field
  typedef logic [3:0]  byteMaskT;    // One enable per byte lane
  typedef logic [1:0]  byteOffsetT;  // Byte within word

  localparam aluCtrlT addAlu = 4'b0100;  // ADD opcode
  localparam aluCtrlT subAlu = 4'b0010;  // SUB opcode

  // Decoded instruction group
  typedef enum logic [2:0] {
    dataProcReg,
    dataProcImm,
    loadStore,
    branch,
    unsupported
  } instrClassE;

  // ARM condition field encodings
  typedef enum logic [3:0] {
    eq = 4'b0000, ne = 4'b0001, cs = 4'b0010, cc = 4'b0011,
    mi = 4'b0100, pl = 4'b0101, vs = 4'b0110, vc = 4'b0111,
    hi = 4'b1000, ls = 4'b1001, ge = 4'b1010, lt = 4'b1011,
    gt = 4'b1100, le = 4'b1101, al = 4'b1110
  } condCodeE;

  // ==========================================================
  // Per-stage control bundles
  // ==========================================================
  typedef struct packed {
    logic [1:0] regSrc;      // Register file read select
    logic [1:0] immSrc;      // Immediate extend select
    logic       aluSrc;      // B operand from immediate
    logic       memtoReg;
    logic       regWrite;
    logic       memWrite;
    logic       branch;
    logic       pcSrc;       // Writes R15
    logic       byteAccess;  // LDRB / STRB
    aluCtrlT    aluControl;
    logic [1:0] flagWrite;   // {NZ, CV}
  } decodeCtrlS;

  // Leaves execute already gated by the condition
  typedef struct packed {
    logic       memWrite;
    logic       memtoReg;
    logic       regWrite;
    logic       pcSrc;
    byteMaskT   byteMask;
    logic       byteAccess;
    byteOffsetT byteOffset;
    logic       setFlags;
    flagsT      nextFlags;
  } memCtrlS;

  typedef struct packed {
    logic       memtoReg;
    logic       regWrite;
    logic       pcSrc;
    logic       loadByte;    // Byte extract on load data
    byteOffsetT byteOffset;
  } wbCtrlS;

endpackage

`default_nettype wire

/* instrDecoder.sv */
`timescale 1ns/1ps
`default_nettype none

module instrDecoder
  import armCtrlPkg::*;
(
  input  instrT      instrD,
  output decodeCtrlS decodeCtrl,
  output logic [1:0] regSrcD,
  output logic [1:0] immSrcD
);

  instrClassE instrClass;
  logic [3:0] opcode;
  logic [3:0] rd;
  logic       sBit;
  logic       loadBit;
  logic       byteBit;
  logic       upBit;
  logic       isCompare;
  logic       miscSpace;
  logic       neverCond;

  // ==========================================================
  // Instruction fields
  // ==========================================================
  assign opcode    = instrD[24:21];
  assign rd        = instrD[15:12];
  assign sBit      = instrD[20];
  assign loadBit   = instrD[20];       // L bit shares position with S
  assign byteBit   = instrD[22];
  assign upBit     = instrD[23];
  assign neverCond = &instrD[31:28];   // 1111 space not handled

  // TST TEQ CMP CMN only touch flags
  assign isCompare = (opcode[3:2] == 2'b10);

  // Compare opcodes without S hold MRS MSR BX CLZ
  assign miscSpace = isCompare & ~sBit;

  // ==========================================================
  // Classification
  // ==========================================================
  always_comb begin
    instrClass = unsupported;
    case (instrD[27:25])
      3'b000: begin
        // Bit 4 set means RSR, multiply or halfword
        if (!instrD[4] && !miscSpace) instrClass = dataProcReg;
      end
      3'b001: begin
        if (!miscSpace) instrClass = dataProcImm;  // MSR imm excluded
      end
      3'b010: instrClass = loadStore;               // Immediate offset
      3'b011: begin
        if (!instrD[4]) instrClass = loadStore;     // Register offset
      end
      3'b101: begin
        if (!instrD[24]) instrClass = branch;       // B only, no link
      end
      default: instrClass = unsupported;            // LDM STM coproc SWI
    endcase
    if (neverCond) instrClass = unsupported;
  end

  // ==========================================================
  // Control pattern per class
  // ==========================================================
  always_comb begin
    decodeCtrl            = '0;
    decodeCtrl.aluControl = addAlu;   // Address adder by default
    case (instrClass)
      dataProcReg, dataProcImm: begin
        decodeCtrl.aluSrc     = (instrClass == dataProcImm);
        decodeCtrl.regWrite   = ~isCompare;
        decodeCtrl.pcSrc      = ~isCompare & (rd == 4'hF);  // Write to PC
        decodeCtrl.aluControl = opcode;
        decodeCtrl.flagWrite  = {2{sBit}};
      end
      loadStore: begin
        decodeCtrl.regSrc     = {~loadBit, 1'b0};   // Store reads Rd
        decodeCtrl.immSrc     = 2'b01;              // 12-bit offset
        decodeCtrl.aluSrc     = ~instrD[25];        // I bit inverted here
        decodeCtrl.memtoReg   = loadBit;
        decodeCtrl.regWrite   = loadBit;
        decodeCtrl.memWrite   = ~loadBit;
        decodeCtrl.byteAccess = byteBit;
        decodeCtrl.aluControl = upBit ? addAlu : subAlu;
      end
      branch: begin
        decodeCtrl.regSrc = 2'b01;   // Rn is PC
        decodeCtrl.immSrc = 2'b10;   // 24-bit word offset
        decodeCtrl.aluSrc = 1'b1;
        decodeCtrl.branch = 1'b1;
        decodeCtrl.pcSrc  = 1'b1;
      end
      default: decodeCtrl = '0;      // All writes off
    endcase
  end

  assign regSrcD = decodeCtrl.regSrc;
  assign immSrcD = decodeCtrl.immSrc;

endmodule

`default_nettype wire

/* condCheck.sv */
`timescale 1ns/1ps
`default_nettype none

module condCheck
  import armCtrlPkg::*;
(
  input  condT       cond,
  input  flagsT      flags,
  input  flagsT      aluFlags,
  input  logic [1:0] flagWrite,
  output logic       condEx,
  output flagsT      nextFlags
);

  logic n;
  logic z;
  logic c;
  logic v;
  logic geFlag;

  assign {n, z, c, v} = flags;
  assign geFlag       = (n == v);   // Signed greater or equal

  // ==========================================================
  // Condition evaluation
  // ==========================================================
  always_comb begin
    case (condCodeE'(cond))
      eq:      condEx = z;
      ne:      condEx = ~z;
      cs:      condEx = c;
      cc:      condEx = ~c;
      mi:      condEx = n;
      pl:      condEx = ~n;
      vs:      condEx = v;
      vc:      condEx = ~v;
      hi:      condEx = c & ~z;          // Unsigned higher
      ls:      condEx = ~c | z;
      ge:      condEx = geFlag;
      lt:      condEx = ~geFlag;
      gt:      condEx = ~z & geFlag;
      le:      condEx = z | ~geFlag;
      al:      condEx = 1'b1;
      default: condEx = 1'b0;            // 1111 never executes
    endcase
  end

  // NZ and CV update independently
  assign nextFlags[3:2] = flagWrite[1] ? aluFlags[3:2] : flags[3:2];
  assign nextFlags[1:0] = flagWrite[0] ? aluFlags[1:0] : flags[1:0];

endmodule

`default_nettype wire

/* executeStage.sv */
`timescale 1ns/1ps
`default_nettype none

module executeStage
  import armCtrlPkg::*;
(
  input  logic       clk,
  input  logic       rstN,
  input  logic       stallE,
  input  logic       flushE,
  input  decodeCtrlS decodeCtrl,
  input  condT       condD,
  input  flagsT      flagsE,       // Forwarded NZCV
  input  flagsT      aluFlagsE,
  input  byteOffsetT aluResultE,   // Low address bits
  output aluCtrlT    aluControlE,
  output logic       aluSrcE,
  output logic       branchTakenE,
  output memCtrlS    memCtrl
);

  decodeCtrlS ctrlE;
  condT       condE;
  logic       condExE;
  flagsT      nextFlagsE;
  logic       memWriteGatedE;
  byteMaskT   byteMaskE;

  // ==========================================================
  // Decode to execute register
  // ==========================================================
  always_ff @(posedge clk) begin
    if (!rstN || flushE) begin       // Flush wins over stall
      ctrlE <= '0;
      condE <= '0;
    end else if (!stallE) begin
      ctrlE <= decodeCtrl;
      condE <= condD;
    end
  end

  condCheck uCondCheck (
    .cond      (condE),
    .flags     (flagsE),
    .aluFlags  (aluFlagsE),
    .flagWrite (ctrlE.flagWrite),
    .condEx    (condExE),
    .nextFlags (nextFlagsE)
  );

  assign aluControlE  = ctrlE.aluControl;
  assign aluSrcE      = ctrlE.aluSrc;
  assign branchTakenE = ctrlE.branch & condExE;

  // ==========================================================
  // Store lane enables
  // ==========================================================
  assign memWriteGatedE = ctrlE.memWrite & condExE;

  always_comb begin
    if (!memWriteGatedE)
      byteMaskE = 4'b0000;                    // No store this cycle
    else if (ctrlE.byteAccess)
      byteMaskE = 4'b0001 << aluResultE;      // One lane for STRB
    else
      byteMaskE = 4'b1111;                    // Full word
  end

  // Gated controls toward memory stage
  always_comb begin
    memCtrl.memWrite   = memWriteGatedE;
    memCtrl.memtoReg   = ctrlE.memtoReg;
    memCtrl.regWrite   = ctrlE.regWrite & condExE;
    memCtrl.pcSrc      = ctrlE.pcSrc & condExE;
    memCtrl.byteMask   = byteMaskE;
    memCtrl.byteAccess = ctrlE.byteAccess;
    memCtrl.byteOffset = aluResultE;
    memCtrl.setFlags   = (|ctrlE.flagWrite) & condExE;
    memCtrl.nextFlags  = nextFlagsE;
  end

endmodule

`default_nettype wire

/* writebackStage.sv */
`timescale 1ns/1ps
`default_nettype none

module writebackStage
  import armCtrlPkg::*;
(
  input  logic     clk,
  input  logic     rstN,
  input  logic     stallM,
  input  logic     flushM,
  input  logic     stallW,
  input  logic     flushW,
  input  memCtrlS  memCtrl,
  output flagsT    flagsE,
  output logic     memWriteM,
  output logic     regWriteM,
  output byteMaskT byteMaskM,
  output wbCtrlS   wbCtrl,
  output flagsT    flags
);

  memCtrlS memCtrlM;
  wbCtrlS  wbNext;
  logic    setFlagsW;
  flagsT   nextFlagsW;
  flagsT   flagsReg;      // Architectural NZCV

  // ==========================================================
  // Memory stage
  // ==========================================================
  always_ff @(posedge clk) begin
    if (!rstN || flushM) memCtrlM <= '0;
    else if (!stallM)    memCtrlM <= memCtrl;
  end

  assign memWriteM = memCtrlM.memWrite;
  assign regWriteM = memCtrlM.regWrite;
  assign byteMaskM = memCtrlM.byteMask;

  always_comb begin
    wbNext.memtoReg   = memCtrlM.memtoReg;
    wbNext.regWrite   = memCtrlM.regWrite;
    wbNext.pcSrc      = memCtrlM.pcSrc;
    wbNext.loadByte   = memCtrlM.memtoReg & memCtrlM.byteAccess;  // LDRB only
    wbNext.byteOffset = memCtrlM.byteOffset;
  end

  // ==========================================================
  // Writeback stage
  // ==========================================================
  always_ff @(posedge clk) begin
    if (!rstN || flushW) begin
      wbCtrl    <= '0;
      setFlagsW <= 1'b0;
    end else if (!stallW) begin
      wbCtrl    <= wbNext;
      setFlagsW <= memCtrlM.setFlags;
    end
  end

  always_ff @(posedge clk) begin
    if (!stallW) nextFlagsW <= memCtrlM.nextFlags;
  end

  // Commit when the W instruction leaves
  always_ff @(posedge clk) begin
    if (!rstN)                      flagsReg <= '0;
    else if (setFlagsW && !stallW)  flagsReg <= nextFlagsW;
  end

  // Visible NZCV includes the W copy
  assign flags = setFlagsW ? nextFlagsW : flagsReg;

  // Newest pending update wins
  assign flagsE = memCtrlM.setFlags ? memCtrlM.nextFlags : flags;

endmodule

`default_nettype wire

/* armController.sv */
`timescale 1ns/1ps
`default_nettype none

module armController
  import armCtrlPkg::*;
(
  input  logic       clk,
  input  logic       rstN,
  input  instrT      instrD,
  input  flagsT      aluFlagsE,
  input  logic [1:0] aluResultE,    // Address low bits
  input  logic       stallE,
  input  logic       stallM,
  input  logic       stallW,
  input  logic       flushE,
  input  logic       flushM,
  input  logic       flushW,
  output logic [1:0] regSrcD,
  output logic [1:0] immSrcD,
  output aluCtrlT    aluControlE,
  output logic       aluSrcE,
  output logic       branchTakenE,
  output logic       memWriteM,
  output logic       regWriteM,
  output byteMaskT   byteMaskM,
  output logic       regWriteW,
  output logic       memtoRegW,
  output logic       pcSrcW,
  output logic       loadByteW,
  output flagsT      flags
);

  decodeCtrlS decodeCtrl;
  memCtrlS    memCtrl;
  wbCtrlS     wbCtrl;
  flagsT      flagsE;

  // ==========================================================
  // Decode
  // ==========================================================
  instrDecoder uInstrDecoder (
    .instrD     (instrD),
    .decodeCtrl (decodeCtrl),
    .regSrcD    (regSrcD),
    .immSrcD    (immSrcD)
  );

  // ==========================================================
  // Execute
  // ==========================================================
  executeStage uExecuteStage (
    .clk          (clk),
    .rstN         (rstN),
    .stallE       (stallE),
    .flushE       (flushE),
    .decodeCtrl   (decodeCtrl),
    .condD        (instrD[31:28]),   // Condition field
    .flagsE       (flagsE),
    .aluFlagsE    (aluFlagsE),
    .aluResultE   (aluResultE),
    .aluControlE  (aluControlE),
    .aluSrcE      (aluSrcE),
    .branchTakenE (branchTakenE),
    .memCtrl      (memCtrl)
  );

  // Memory and writeback with flags
  writebackStage uWritebackStage (
    .clk       (clk),
    .rstN      (rstN),
    .stallM    (stallM),
    .flushM    (flushM),
    .stallW    (stallW),
    .flushW    (flushW),
    .memCtrl   (memCtrl),
    .flagsE    (flagsE),
    .memWriteM (memWriteM),
    .regWriteM (regWriteM),
    .byteMaskM (byteMaskM),
    .wbCtrl    (wbCtrl),
    .flags     (flags)
  );

  assign regWriteW = wbCtrl.regWrite;
  assign memtoRegW = wbCtrl.memtoReg;
  assign pcSrcW    = wbCtrl.pcSrc;
  assign loadByteW = wbCtrl.loadByte;

endmodule

`default_nettype wire

/* controllerChecker.sv */
`timescale 1ns/1ps
`default_nettype none

module controllerChecker (
  input  logic         clk,
  input  logic         checkEn,      // Current line is valid
  input  logic         testEnd,      // Current line closes a test
  input  logic [127:0] testName,
  input  logic [23:0]  expVec,
  input  logic [1:0]   regSrcD,
  input  logic [1:0]   immSrcD,
  input  logic [3:0]   aluControlE,
  input  logic         aluSrcE,
  input  logic         branchTakenE,
  input  logic         memWriteM,
  input  logic         regWriteM,
  input  logic [3:0]   byteMaskM,
  input  logic         regWriteW,
  input  logic         memtoRegW,
  input  logic         pcSrcW,
  input  logic         loadByteW,
  input  logic [3:0]   flags,
  output int           passCount,
  output int           failCount
);

  logic [23:0] actVec;
  logic [23:0] firstExp;
  logic [23:0] firstAct;
  logic        testBad;
  int          lineNo;
  int          badLine;

  // Decode selects lead, then the trace column order
  assign actVec = {regSrcD, immSrcD,
                   aluControlE, aluSrcE, branchTakenE, memWriteM, regWriteM,
                   byteMaskM, regWriteW, memtoRegW, pcSrcW, loadByteW, flags};

  initial begin
    passCount = 0;
    failCount = 0;
    testBad   = 1'b0;
    lineNo    = 0;
    badLine   = 0;
    firstExp  = '0;
    firstAct  = '0;
  end

  // ==========================================================
  // Compare at negedge, away from the drive edge
  // ==========================================================
  always @(negedge clk) begin
    if (checkEn) begin
      if ((actVec !== expVec) && !testBad) begin   // Keep first mismatch only
        testBad  = 1'b1;
        firstExp = expVec;
        firstAct = actVec;
        badLine  = lineNo;
      end
      if (testEnd) begin
        if (testBad) begin
          $display("FAILED %0s at trace line %0d expected %06h actual %06h",
                   testName, badLine, firstExp, firstAct);
          failCount++;
        end else begin
          $display("PASS %0s", testName);
          passCount++;
        end
        testBad = 1'b0;
      end
      lineNo++;
    end
  end

endmodule

`default_nettype wire

/* armControllerTb.sv */
`timescale 1ns/1ps
`default_nettype none

module armControllerTb;

  localparam int maxLines    = 64;
  localparam int resetCycles = 16;
  localparam int clkPeriod   = 20;   // ns

  logic        clk;
  logic        rstN;
  logic [31:0] instrD;
  logic [3:0]  aluFlagsE;
  logic [1:0]  aluResultE;
  logic        stallE, stallM, stallW;
  logic        flushE, flushM, flushW;

  // Trace contents, one entry per cycle
  logic [127:0] traceName [maxLines];
  logic [31:0]  traceInstr [maxLines];
  logic [3:0]   traceAluFlags [maxLines];
  logic [1:0]   traceResult [maxLines];
  logic [2:0]   traceStall [maxLines];   // {E, M, W}
  logic [2:0]   traceFlush [maxLines];   // {E, M, W}
  logic [19:0]  traceExp [maxLines];
  int           lineCount;
  logic         traceLoaded;

  // Toward the checker
  logic         checkEn;
  logic         testEnd;
  logic [127:0] testName;
  logic [23:0]  expVec;      // Decode selects above the trace columns
  int           passCount;
  int           failCount;

  initial clk = 1'b0;
  always #(clkPeriod / 2) clk = ~clk;

  // Outputs are tapped by the checker through the hierarchy
  armController i_dut (
    .clk(clk), .rstN(rstN), .instrD(instrD), .aluFlagsE(aluFlagsE),
    .aluResultE(aluResultE), .stallE(stallE), .stallM(stallM), .stallW(stallW),
    .flushE(flushE), .flushM(flushM), .flushW(flushW),
    .regSrcD(), .immSrcD(), .aluControlE(), .aluSrcE(), .branchTakenE(),
    .memWriteM(), .regWriteM(), .byteMaskM(), .regWriteW(), .memtoRegW(),
    .pcSrcW(), .loadByteW(), .flags()
  );

  controllerChecker uChecker (
    .clk(clk), .checkEn(checkEn), .testEnd(testEnd), .testName(testName),
    .expVec(expVec),
    .regSrcD(i_dut.regSrcD), .immSrcD(i_dut.immSrcD),
    .aluControlE(i_dut.aluControlE), .aluSrcE(i_dut.aluSrcE),
    .branchTakenE(i_dut.branchTakenE), .memWriteM(i_dut.memWriteM),
    .regWriteM(i_dut.regWriteM), .byteMaskM(i_dut.byteMaskM),
    .regWriteW(i_dut.regWriteW), .memtoRegW(i_dut.memtoRegW),
    .pcSrcW(i_dut.pcSrcW), .loadByteW(i_dut.loadByteW), .flags(i_dut.flags),
    .passCount(passCount), .failCount(failCount)
  );

  // ==========================================================
  // Trace file reader
  // ==========================================================
  task automatic loadTrace();
    int fd;
    int code;
    logic [8*160-1:0] lineBuf;
    logic [127:0] nameV;
    logic [31:0] instrV, afV, resV, stlV, flsV, aluCV, aluSV, brV;
    logic [31:0] memWV, regWMV, maskV, regWWV, m2rV, pcV, lbV, flV;
    lineCount = 0;
    fd = $fopen("ctrlTrace.txt", "r");
    if (fd != 0) begin
      while (!$feof(fd) && lineCount < maxLines) begin
        lineBuf = '0;
        code = $fgets(lineBuf, fd);
        code = $sscanf(lineBuf, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                       nameV, instrV, afV, resV, stlV, flsV, aluCV, aluSV, brV,
                       memWV, regWMV, maskV, regWWV, m2rV, pcV, lbV, flV);
        if (code == 17) begin   // Comment and blank lines fall short
          traceName[lineCount]     = nameV;
          traceInstr[lineCount]    = instrV;
          traceAluFlags[lineCount] = afV[3:0];
          traceResult[lineCount]   = resV[1:0];
          traceStall[lineCount]    = stlV[2:0];
          traceFlush[lineCount]    = flsV[2:0];
          traceExp[lineCount]      = {aluCV[3:0], aluSV[0], brV[0], memWV[0], regWMV[0],
                                      maskV[3:0], regWWV[0], m2rV[0], pcV[0], lbV[0],
                                      flV[3:0]};
          lineCount++;
        end
      end
      $fclose(fd);
    end
  endtask

  // Expected decode selects as {regSrc, immSrc}
  // regSrc[1] picks Rd for a store and regSrc[0] picks PC as base
  // immSrc 01 is the 12-bit offset and 10 the 24-bit branch offset
  function automatic logic [3:0] operandSelects(input logic [31:0] instr);
    logic [3:0] sel;
    logic       isMem;
    logic       isBranch;
    isMem    = (instr[27:26] == 2'b01) && !(instr[25] && instr[4]);
    isBranch = (instr[27:24] == 4'b1010);   // B without link
    sel      = 4'b0000;                     // Data processing and bubbles
    if (instr[31:28] != 4'hF) begin
      if (isMem)
        sel = {~instr[20], 1'b0, 2'b01};
      else if (isBranch)
        sel = 4'b0110;
    end
    return sel;
  endfunction

  // ==========================================================
  // Stimulus
  // ==========================================================
  initial begin
    rstN        = 1'b0;
    instrD      = 32'hF000_0000;   // Never condition, decodes as bubble
    aluFlagsE   = '0;
    aluResultE  = '0;
    {stallE, stallM, stallW} = '0;
    {flushE, flushM, flushW} = '0;
    checkEn     = 1'b0;
    testEnd     = 1'b0;
    testName    = '0;
    expVec      = '0;
    traceLoaded = 1'b0;
    loadTrace();
    if (lineCount == 0) begin
      $display("Trace file ctrlTrace.txt could not be read or holds no lines");
      $display("Regression failed");
      $finish;
    end else begin
      traceLoaded = 1'b1;
      repeat (resetCycles) @(posedge clk);
      rstN <= 1'b1;
      for (int j = 0; j < lineCount; j++) begin
        @(posedge clk);
        instrD     <= traceInstr[j];
        aluFlagsE  <= traceAluFlags[j];
        aluResultE <= traceResult[j];
        {stallE, stallM, stallW} <= traceStall[j];
        {flushE, flushM, flushW} <= traceFlush[j];
        checkEn    <= 1'b1;
        testName   <= traceName[j];
        expVec     <= {operandSelects(traceInstr[j]), traceExp[j]};
        if (j == lineCount - 1) testEnd <= 1'b1;   // Last line closes its test
        else testEnd <= (traceName[j + 1] != traceName[j]);
      end
      @(posedge clk);
      checkEn <= 1'b0;
      testEnd <= 1'b0;
      @(negedge clk);
      #1;
      $display("Tests passed: %0d, tests failed: %0d", passCount, failCount);
      if (failCount > 0) begin
        $display("Regression failed");
      end else begin
        $display("Regression passed");
      end
      $finish;
    end
  end

  // Watchdog sized from the trace
  initial begin
    wait (traceLoaded);
    #((lineCount + 50) * clkPeriod);
    $display("Watchdog expired, the trace did not finish in time");
    $display("Regression failed");
    $finish;
  end

endmodule

`default_nettype wire

/* ctrlTrace.txt */
# name instr aluFlagsE aluResultE stall{EMW} flush{EMW} | expected: aluControlE aluSrcE
# branchTakenE memWriteM regWriteM byteMaskM regWriteW memtoRegW pcSrcW loadByteW flags
aluDecode   E0821003 0 0 0 0  0 0 0 0 0 0 0 0 0 0 0
aluDecode   F0000000 0 0 0 0  4 0 0 0 0 0 0 0 0 0 0
aluDecode   E2821005 0 0 0 0  0 0 0 0 1 0 0 0 0 0 0
aluDecode   F0000000 0 0 0 0  4 1 0 0 0 0 1 0 0 0 0
condGate    00824003 0 0 0 0  0 0 0 0 1 0 0 0 0 0 0
condGate    05821000 0 0 0 0  4 0 0 0 0 0 1 0 0 0 0
condGate    0A000010 0 0 0 0  4 1 0 0 0 0 0 0 0 0 0
condGate    10824003 0 0 0 0  4 1 0 0 0 0 0 0 0 0 0
condGate    15821000 0 0 0 0  4 0 0 0 0 0 0 0 0 0 0
condGate    1A000010 0 0 0 0  4 1 0 0 1 0 0 0 0 0 0
flagForward E0565007 0 0 0 0  4 1 1 1 0 F 1 0 0 0 0
flagForward 00824003 4 0 0 0  2 0 0 0 0 0 0 0 0 0 0
flagForward F0000000 0 0 0 0  4 0 0 0 1 0 0 0 1 0 0
flagForward E5C21000 0 0 0 0  0 0 0 0 1 0 1 0 0 0 4
flagForward E5C21000 0 0 0 0  4 1 0 0 0 0 1 0 0 0 4
storeMask   E5C21000 0 1 0 0  4 1 0 1 0 1 0 0 0 0 4
storeMask   E5C21000 0 2 0 0  4 1 0 1 0 2 0 0 0 0 4
storeMask   E5821000 0 3 0 0  4 1 0 1 0 4 0 0 0 0 4
storeMask   E5921000 0 0 0 0  4 1 0 1 0 8 0 0 0 0 4
storeMask   E5D21000 0 0 0 0  4 1 0 1 0 F 0 0 0 0 4
loadBranch  EA000010 0 0 0 0  4 1 0 0 1 0 0 0 0 0 4
loadBranch  EA000010 0 0 0 4  4 1 1 0 1 0 1 1 0 0 4
loadBranch  F0000000 0 0 0 0  0 0 0 0 0 0 1 1 0 1 4
loadBranch  E2421005 0 0 0 0  0 0 0 0 0 0 0 0 1 0 4
stallHold   F0000000 0 0 4 2  2 1 0 0 0 0 0 0 0 0 4
stallHold   F0000000 0 0 4 2  2 1 0 0 0 0 0 0 0 0 4
stallHold   F0000000 0 0 0 0  2 1 0 0 0 0 0 0 0 0 4
stallHold   F0000000 0 0 0 0  0 0 0 0 1 0 0 0 0 0 4
stallHold   F0000000 0 0 0 0  0 0 0 0 0 0 1 0 0 0 4
stallHold   F0000000 0 0 0 0  0 0 0 0 0 0 0 0 0 0 4

/* sim.f */
armCtrlPkg.sv
instrDecoder.sv
condCheck.sv
executeStage.sv
writebackStage.sv
armController.sv
controllerChecker.sv
armControllerTb.sv
